// File: include/icache_defines.svh
// instruction cache geometry and credit settings
// shared by the cache RTL and its testbench
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ############################
// line geometry
// ############################
`define ICACHE_INDEX_BITS    6                  // 64 lines
`define ICACHE_LINE_WORDS    16                 // 64-byte lines
`define ICACHE_WORD_BITS     4                  // word select within a line
`define ICACHE_OFFSET_BITS   6                  // byte offset within a line
`define ICACHE_TAG_BITS      20                 // addr 31..12
`define ICACHE_RAM_AW        10                 // index plus word select

// ############################
// flow control
// ############################
`define ICACHE_REQ_DEPTH     4                  // also initial request credits
`define ICACHE_RSP_CREDITS   4                  // granted at reset
`define ICACHE_CREDIT_BITS   3

`define ICACHE_UNCACHED_BIT  31

`endif

// File: hdl/icache_pkg.sv
// instruction cache types
// fetch port, AXI read channels and refill request payloads
package icache_pkg;

    // fetch side
    typedef struct packed {
        logic [31:0] addr;              // word aligned
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] addr;              // echoed request address
        logic [31:0] data;
    } fetch_rsp_t;

    // ############################
    // AXI read channels
    // ############################
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [3:0]  len;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } axi_r_t;

    // lookup to refill engine
    typedef struct packed {
        logic [31:0] addr;              // line base, or exact word if uncached
        logic        uncached;
    } refill_req_t;

endpackage

// File: hdl/icache_req_queue.sv
// fetch request queue
// holds requests sent against credits and frees one credit per pop
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_req_queue (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   req_valid,
    input  icache_pkg::fetch_req_t req,
    input  logic                   q_pop,
    output logic                   q_valid,
    output icache_pkg::fetch_req_t q_req,
    output logic                   req_credit
);
    import icache_pkg::*;

    localparam int DEPTH = `ICACHE_REQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    fetch_req_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop;

    assign q_valid    = count != '0;
    assign q_req      = mem[rd_ptr];
    assign pop        = q_pop && q_valid;
    assign req_credit = pop;              // entry freed, credit back

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, req_valid} - {{PTR_W{1'b0}}, pop};
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid) begin
            mem[wr_ptr] <= req;
        end
    end

    // ############################
    // credit protocol
    // ############################
    // the requester only sends with a credit in hand, so a full queue
    // can never see a push
    a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
        req_valid |-> count != DEPTH[PTR_W:0]);

endmodule

// File: hdl/icache_tag_stage.sv
// tag lookup stage
// tag and valid arrays, hit/miss decision, uncached word buffer
// and the response credit counter
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tag_stage (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      q_valid,
    input  icache_pkg::fetch_req_t    q_req,
    input  logic                      rsp_credit,
    input  logic                      refill_done,
    input  logic [31:0]               uc_word,
    output logic                      q_pop,
    output logic                      refill_start,
    output icache_pkg::refill_req_t   refill_req,
    output logic [`ICACHE_RAM_AW-1:0] ram_raddr,
    output logic                      rd_valid,
    output logic [31:0]               rd_addr,
    output logic                      rd_uncached,
    output logic [31:0]               uc_data
);
    localparam int LINES = 1 << `ICACHE_INDEX_BITS;

    logic [`ICACHE_TAG_BITS-1:0]    tag_mem [LINES];
    logic [LINES-1:0]               valid_q;
    logic [`ICACHE_INDEX_BITS-1:0]  idx;
    logic [`ICACHE_TAG_BITS-1:0]    tag;
    logic                           uncached;
    logic                           cached_hit;
    logic                           hit;
    logic                           miss_pending;
    logic                           uc_ready;     // uncached word waiting
    logic                           credit_ok;
    logic [`ICACHE_CREDIT_BITS-1:0] rsp_cnt;

    assign idx        = q_req.addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign tag        = q_req.addr[31 -: `ICACHE_TAG_BITS];
    assign uncached   = q_req.addr[`ICACHE_UNCACHED_BIT];
    assign cached_hit = !uncached && valid_q[idx] && (tag_mem[idx] == tag);
    assign hit        = cached_hit || (uncached && uc_ready);

    // response in flight already holds one of the counted credits
    assign credit_ok  = rsp_cnt > {{(`ICACHE_CREDIT_BITS-1){1'b0}}, rd_valid};

    assign q_pop        = q_valid && !miss_pending && hit && credit_ok;
    assign refill_start = q_valid && !miss_pending && !hit;

    assign refill_req.uncached = uncached;
    assign refill_req.addr     = uncached ? q_req.addr :
        {q_req.addr[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};

    assign ram_raddr = q_req.addr[2 +: `ICACHE_RAM_AW];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid_q      <= '0;
            miss_pending <= 1'b0;
            uc_ready     <= 1'b0;
            rd_valid     <= 1'b0;
            rsp_cnt      <= `ICACHE_CREDIT_BITS'(`ICACHE_RSP_CREDITS);
        end else begin
            rd_valid <= q_pop;
            rsp_cnt  <= rsp_cnt + {{(`ICACHE_CREDIT_BITS-1){1'b0}}, rsp_credit}
                                - {{(`ICACHE_CREDIT_BITS-1){1'b0}}, rd_valid};
            if (refill_start) begin
                miss_pending <= 1'b1;
                if (!uncached) begin
                    valid_q[idx] <= 1'b0;           // line under refill
                end
            end
            if (refill_done) begin
                miss_pending <= 1'b0;
                if (uncached) begin
                    uc_ready <= 1'b1;
                end else begin
                    valid_q[idx] <= 1'b1;
                end
            end
            if (q_pop && uncached) begin
                uc_ready <= 1'b0;                   // never allocates
            end
        end
    end

    // head stays put while stalled, so q_req still names the missed line
    always_ff @(posedge aclk) begin
        if (refill_start && !uncached) begin
            tag_mem[idx] <= tag;
        end
        if (refill_done && uncached) begin
            uc_data <= uc_word;
        end
        if (q_pop) begin
            rd_addr     <= q_req.addr;
            rd_uncached <= uncached;
        end
    end

    a_rsp_credit: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_valid |-> rsp_cnt != '0);

endmodule

// File: hdl/icache_refill.sv
// line refill engine
// issues one AXI read burst per miss and writes each beat to the data RAM,
// or captures a single uncached word
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_refill (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      refill_start,
    input  icache_pkg::refill_req_t   refill_req,
    input  logic                      arready,
    input  icache_pkg::axi_r_t        r,
    input  logic                      rvalid,
    output icache_pkg::axi_ar_t       ar,
    output logic                      arvalid,
    output logic                      rready,
    output logic                      ram_we,
    output logic [`ICACHE_RAM_AW-1:0] ram_waddr,
    output logic [31:0]               ram_wdata,
    output logic                      refill_done,
    output logic [31:0]               uc_word
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_DONE
    } state_t;

    state_t                       state;
    logic [`ICACHE_WORD_BITS-1:0] beat;
    logic                         uncached;
    logic                         beat_ok;

    assign arvalid     = state == S_ADDR;
    assign rready      = state == S_DATA;
    assign refill_done = state == S_DONE;
    assign beat_ok     = rvalid && rready;

    // ############################
    // RAM write port
    // ############################
    assign ram_we    = beat_ok && !uncached;
    assign ram_waddr = {ar.addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS], beat};
    assign ram_wdata = r.data;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= S_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (refill_start) begin
                        state <= S_ADDR;
                        beat  <= '0;
                    end
                end
                S_ADDR: begin
                    if (arready) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (beat_ok) begin
                        beat <= beat + 1'b1;
                        if (r.last) begin
                            state <= S_DONE;
                        end
                    end
                end
                S_DONE: state <= S_IDLE;          // one-cycle done pulse
                default: state <= S_IDLE;
            endcase
        end
    end

    // AR held from start until the handshake
    always_ff @(posedge aclk) begin
        if (state == S_IDLE && refill_start) begin
            ar.id    <= refill_req.uncached ? 4'd2 : 4'd1;
            ar.addr  <= refill_req.addr;
            ar.len   <= refill_req.uncached ? 4'd0 : 4'(`ICACHE_LINE_WORDS - 1);
            uncached <= refill_req.uncached;
        end
        if (beat_ok && uncached) begin
            uc_word <= r.data;
        end
    end

    // memory ends the burst exactly on the requested length
    a_last_beat: assert property (@(posedge aclk) disable iff (!aresetn)
        beat_ok |-> (r.last == (beat == ar.len)));

endmodule

// File: hdl/icache_data_ram.sv
// line data RAM
// one write port, one registered read port, one word per entry
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_ram (
    input  logic                      aclk,
    input  logic                      we,
    input  logic [`ICACHE_RAM_AW-1:0] waddr,
    input  logic [31:0]               wdata,
    input  logic [`ICACHE_RAM_AW-1:0] raddr,
    output logic [31:0]               rdata
);
    localparam int WORDS = 1 << `ICACHE_RAM_AW;

    logic [31:0] mem [WORDS];           // 64 lines x 16 words

    always_ff @(posedge aclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

// File: hdl/icache_top.sv
// instruction cache top level
// request queue, tag stage, refill engine and data RAM, with the
// response mux on the fetch side and an AXI read-only memory port
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_top (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   req_valid,
    input  icache_pkg::fetch_req_t req,
    output logic                   req_credit,
    output logic                   rsp_valid,
    output icache_pkg::fetch_rsp_t rsp,
    input  logic                   rsp_credit,
    output icache_pkg::axi_ar_t    ar,
    output logic                   arvalid,
    input  logic                   arready,
    output logic [2:0]             arsize,
    output logic [1:0]             arburst,
    input  icache_pkg::axi_r_t     r,
    input  logic                   rvalid,
    output logic                   rready
);
    import icache_pkg::*;

    fetch_req_t                q_req;
    logic                      q_valid;
    logic                      q_pop;
    refill_req_t               refill_req;
    logic                      refill_start;
    logic                      refill_done;
    logic [31:0]               uc_word;
    logic [31:0]               uc_data;
    logic                      ram_we;
    logic [`ICACHE_RAM_AW-1:0] ram_waddr;
    logic [`ICACHE_RAM_AW-1:0] ram_raddr;
    logic [31:0]               ram_wdata;
    logic [31:0]               ram_rdata;
    logic                      rd_valid;
    logic [31:0]               rd_addr;
    logic                      rd_uncached;

    assign arsize  = 3'b010;             // 4-byte beats
    assign arburst = 2'b01;              // INCR

    icache_req_queue u_queue (
        .aclk(aclk), .aresetn(aresetn), .req_valid(req_valid), .req(req),
        .q_pop(q_pop), .q_valid(q_valid), .q_req(q_req), .req_credit(req_credit)
    );

    icache_tag_stage u_tag (
        .aclk(aclk), .aresetn(aresetn), .q_valid(q_valid), .q_req(q_req),
        .rsp_credit(rsp_credit), .refill_done(refill_done), .uc_word(uc_word),
        .q_pop(q_pop), .refill_start(refill_start), .refill_req(refill_req),
        .ram_raddr(ram_raddr), .rd_valid(rd_valid), .rd_addr(rd_addr),
        .rd_uncached(rd_uncached), .uc_data(uc_data)
    );

    icache_refill u_refill (
        .aclk(aclk), .aresetn(aresetn), .refill_start(refill_start),
        .refill_req(refill_req), .arready(arready), .r(r), .rvalid(rvalid),
        .ar(ar), .arvalid(arvalid), .rready(rready), .ram_we(ram_we),
        .ram_waddr(ram_waddr), .ram_wdata(ram_wdata), .refill_done(refill_done),
        .uc_word(uc_word)
    );

    icache_data_ram u_ram (
        .aclk(aclk), .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
        .raddr(ram_raddr), .rdata(ram_rdata)
    );

    // ############################
    // data stage
    // ############################
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_valid) begin
            rsp.addr <= rd_addr;
            rsp.data <= rd_uncached ? uc_data : ram_rdata;
        end
    end

endmodule

// File: verification/tb_clock_gen.sv
// testbench clock and reset
// 40 ns clock, active-low reset held for the first 3 cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic aclk,
    output logic aresetn
);
    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    initial begin
        aresetn = 1'b0;
        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;                // released on a rising edge
    end

endmodule

// File: verification/icache_tb.sv
// instruction cache testbench
// random fetch stream checked against a reference cache model, with an
// AXI read memory model and a consumer that returns response credits
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int          NUM_REQ     = 600;
    localparam int          TIMEOUT     = NUM_REQ * 40;   // cycles
    localparam int          LINES       = 1 << `ICACHE_INDEX_BITS;
    localparam logic [31:0] DATA_KEY    = 32'hA5A5_0000;
    localparam int          HOLD_AT     = 200;            // responses before the stall
    localparam int          HOLD_CYCLES = 80;

    typedef enum logic [1:0] {MEM_IDLE, MEM_AR_WAIT, MEM_AR_TAKE, MEM_BEATS} mem_state_t;

    logic       aclk;
    logic       aresetn;
    logic       req_valid  = 1'b0;
    fetch_req_t req        = '0;
    logic       req_credit;
    logic       rsp_valid;
    fetch_rsp_t rsp;
    logic       rsp_credit = 1'b0;
    axi_ar_t    ar;
    logic       arvalid;
    logic       arready    = 1'b0;
    logic [2:0] arsize;
    logic [1:0] arburst;
    axi_r_t     r          = '0;
    logic       rvalid     = 1'b0;
    logic       rready;

    integer seed      = 34;
    int     cycle_cnt = 0;

    // reference cache model
    logic [`ICACHE_TAG_BITS-1:0] model_tag [LINES];
    logic [LINES-1:0]            model_valid = '0;
    fetch_rsp_t                  exp_rsp [$];
    axi_ar_t                     exp_ar [$];
    int                          model_hits      = 0;
    int                          model_conflicts = 0;

    int          req_credits   = `ICACHE_REQ_DEPTH;
    int          sent          = 0;
    int          credit_pulses = 0;
    logic [31:0] last_addr     = '0;
    mem_state_t  mem_state     = MEM_IDLE;
    axi_ar_t     held_ar;
    int          ar_wait;
    int          beat_idx;
    int          cache_credits = `ICACHE_RSP_CREDITS;
    int          owed          = 0;
    int          rsp_count     = 0;
    int          hold_left     = 0;
    logic        hold_done     = 1'b0;
    logic        final_ok;

    tb_clock_gen u_clk (.aclk(aclk), .aresetn(aresetn));

    icache_top UUT (
        .aclk(aclk), .aresetn(aresetn), .req_valid(req_valid), .req(req),
        .req_credit(req_credit), .rsp_valid(rsp_valid), .rsp(rsp), .rsp_credit(rsp_credit),
        .ar(ar), .arvalid(arvalid), .arready(arready), .arsize(arsize), .arburst(arburst),
        .r(r), .rvalid(rvalid), .rready(rready)
    );

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        mem_word = addr ^ DATA_KEY;
    endfunction

    task automatic stop_with_error(input string what);
        $display("ERROR at cycle %0d: %s", cycle_cnt, what);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("CHECK FAILED %s got %h expected %h", name, got, want);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at cycle %0d", cycle_cnt);
    endtask

    task automatic check_rsp(input fetch_rsp_t got, input fetch_rsp_t want);
        if (got.addr !== want.addr) begin
            report_mismatch("rsp.addr", got.addr, want.addr);
        end else if (got.data !== want.data) begin
            report_mismatch("rsp.data", got.data, want.data);
        end
    endtask

    task automatic check_ar(input string label, input axi_ar_t got, input axi_ar_t want);
        if (got.id !== want.id) begin
            report_mismatch({label, ".id"}, 32'(got.id), 32'(want.id));
        end else if (got.addr !== want.addr) begin
            report_mismatch({label, ".addr"}, got.addr, want.addr);
        end else if (got.len !== want.len) begin
            report_mismatch({label, ".len"}, 32'(got.len), 32'(want.len));
        end
    endtask

    // expected response, and the burst a miss must cause
    task automatic predict(input logic [31:0] addr);
        logic [`ICACHE_INDEX_BITS-1:0] idx;
        logic [`ICACHE_TAG_BITS-1:0]   tag;
        axi_ar_t                       miss_ar;
        fetch_rsp_t                    resp;
        idx       = addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
        tag       = addr[31 -: `ICACHE_TAG_BITS];
        resp.addr = addr;
        resp.data = mem_word(addr);
        exp_rsp.push_back(resp);
        if (addr[`ICACHE_UNCACHED_BIT]) begin
            miss_ar.id   = 4'd2;
            miss_ar.addr = addr;
            miss_ar.len  = 4'd0;
            exp_ar.push_back(miss_ar);
        end else if (model_valid[idx] && model_tag[idx] == tag) begin
            model_hits++;
        end else begin
            if (model_valid[idx]) begin
                model_conflicts++;                      // evicts another tag
            end
            miss_ar.id   = 4'd1;
            miss_ar.addr = {addr[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
            miss_ar.len  = 4'(`ICACHE_LINE_WORDS - 1);
            exp_ar.push_back(miss_ar);
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
        end
    endtask

    task automatic next_fetch_addr(output logic [31:0] addr);
        int pick;
        int rnd;
        pick = $random(seed);
        rnd  = $random(seed);
        if (pick[0]) begin
            addr = {18'd0, last_addr[13:2] + 12'd1, 2'b00};   // straight-line fetch
        end else begin
            addr = {18'd0, rnd[13:2], 2'b00};                 // 16 KB window
        end
        last_addr = addr;
        if (pick[3:1] == 3'b000) begin
            addr[`ICACHE_UNCACHED_BIT] = 1'b1;
        end
    endtask

    // ##############################
    // requester
    // ##############################
    always @(posedge aclk) begin : requester
        logic [31:0] addr;
        int          pick;
        if (aresetn) begin
            if (req_credit) begin
                req_credits++;
                credit_pulses++;
            end
            if (credit_pulses > sent || req_credits > `ICACHE_REQ_DEPTH) begin
                stop_with_error("req_credit pulse without an accepted request");
            end
            pick = $random(seed);
            if (sent < NUM_REQ && req_credits > 0 && pick[1:0] != 2'b00) begin
                next_fetch_addr(addr);
                predict(addr);
                req_valid <= 1'b1;
                req.addr  <= addr;
                req_credits--;
                sent++;
            end else begin
                req_valid <= 1'b0;
            end
        end
    end

    // ##############################
    // AXI read memory
    // ##############################
    always @(posedge aclk) begin : memory_model
        axi_r_t beat;
        int     gap;
        if (aresetn) begin
            if (rready !== (mem_state == MEM_BEATS)) begin
                stop_with_error("rready does not match the refill data phase");
            end
            case (mem_state)
                MEM_IDLE: begin
                    if (arvalid) begin
                        held_ar = ar;
                        ar_wait = $random(seed) & 3;
                        mem_state = (ar_wait == 0) ? MEM_AR_TAKE : MEM_AR_WAIT;
                        arready <= (ar_wait == 0);
                    end
                end
                MEM_AR_WAIT: begin
                    check_ar("ar held", ar, held_ar);
                    ar_wait--;
                    if (ar_wait == 0) begin
                        arready   <= 1'b1;
                        mem_state = MEM_AR_TAKE;
                    end
                end
                MEM_AR_TAKE: begin
                    if (!arvalid) begin
                        stop_with_error("arvalid dropped before the AR handshake");
                    end
                    if (exp_ar.size() == 0) begin
                        stop_with_error("AR issued where the model predicts a hit");
                    end
                    if (arsize !== 3'b010 || arburst !== 2'b01) begin
                        stop_with_error("AR is not a 4-byte INCR burst");
                    end
                    check_ar("ar", ar, exp_ar.pop_front());
                    arready   <= 1'b0;
                    held_ar   = ar;
                    beat_idx  = 0;
                    mem_state = MEM_BEATS;
                end
                MEM_BEATS: begin
                    if (rvalid && rready && r.last) begin
                        rvalid    <= 1'b0;
                        mem_state = MEM_IDLE;
                    end else if (!rvalid || rready) begin
                        if (rvalid) begin
                            beat_idx++;
                        end
                        gap = $random(seed);
                        beat.id   = held_ar.id;
                        beat.data = mem_word(held_ar.addr + 32'(beat_idx * 4));
                        beat.resp = 2'b00;
                        beat.last = beat_idx == int'(held_ar.len);
                        r      <= beat;
                        rvalid <= gap[1:0] != 2'b00;    // random gap between beats
                    end
                end
                default: mem_state = MEM_IDLE;
            endcase
        end
    end

    // ##############################
    // consumer
    // ##############################
    always @(posedge aclk) begin : consumer
        int pick;
        if (aresetn) begin
            if (rsp_valid) begin
                if (cache_credits == 0) begin
                    stop_with_error("rsp_valid with no response credit granted");
                end
                if (exp_rsp.size() == 0) begin
                    stop_with_error("response with no outstanding request");
                end
                check_rsp(rsp, exp_rsp.pop_front());
                cache_credits--;
                owed++;
                rsp_count++;
            end
            if (!hold_done && rsp_count >= HOLD_AT) begin
                hold_left = HOLD_CYCLES;                // withhold credits for a while
                hold_done = 1'b1;
            end
            pick = $random(seed);
            if (hold_left > 0) begin
                hold_left--;
                rsp_credit <= 1'b0;
            end else if (owed > 0 && pick[0]) begin
                rsp_credit <= 1'b1;
                owed--;
                cache_credits++;
            end else begin
                rsp_credit <= 1'b0;
            end
        end
    end

    always @(posedge aclk) begin : watchdog
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            stop_with_error($sformatf("timeout with %0d of %0d responses", rsp_count, NUM_REQ));
        end
    end

    initial begin : main
        while (rsp_count < NUM_REQ) begin
            @(posedge aclk);
        end
        repeat (8) @(posedge aclk);                     // catch stray responses or bursts
        final_ok = exp_ar.size() == 0 && credit_pulses == NUM_REQ
                   && req_credits == `ICACHE_REQ_DEPTH && hold_done
                   && model_hits > 0 && model_conflicts > 0;
        $display("responses %0d, hits %0d, conflict misses %0d",
                 rsp_count, model_hits, model_conflicts);
        if (final_ok) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_with_error($sformatf(
                "end of run: %0d bursts missing, %0d credit pulses, %0d requester credits",
                exp_ar.size(), credit_pulses, req_credits));
        end
    end

endmodule

// File: icache_sub.f
+incdir+include
hdl/icache_pkg.sv
hdl/icache_req_queue.sv
hdl/icache_tag_stage.sv
hdl/icache_refill.sv
hdl/icache_data_ram.sv
hdl/icache_top.sv
verification/tb_clock_gen.sv
verification/icache_tb.sv

// File: Makefile
# Verilator flow for the instruction cache testbench
# every variable can be overridden, e.g. make sim OBJ_DIR=build

VERILATOR  ?= verilator
TOP        ?= icache_tb
FILELIST   ?= icache_sub.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG   ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
